// File: logic/na_pkg.sv
`default_nettype none

package na_pkg;

   // Link and bus widths
   localparam int DATA_W    = 32;
   localparam int ADDR_W    = 24;
   localparam int VCHANNELS = 2;

   // Buffer depths in flits
   localparam int RX_DEPTH = 16;
   localparam int TX_DEPTH = 4;

   typedef logic [DATA_W-1:0]            data_t;
   typedef logic [$clog2(VCHANNELS)-1:0] vc_t;

   // One link flit, 34 bits
   typedef struct packed {
      logic  last;
      logic  first;
      data_t data;
   } flit_t;

   // Region select, address bits 21:20
   localparam logic [1:0] REGION_CONF = 2'd0;
   localparam logic [1:0] REGION_MP   = 2'd1;

   // Configuration region, word offsets
   localparam logic [7:0] OFS_TILEID = 8'h00; // Read only
   localparam logic [7:0] OFS_NVC    = 8'h04; // Read only
   localparam logic [7:0] OFS_IRQ_EN = 8'h08; // Enable in bit 0

   // Message-passing region, bit 8 picks the virtual channel
   localparam logic [7:0] OFS_MP_DATA   = 8'h00;
   localparam logic [7:0] OFS_MP_LAST   = 8'h04;
   localparam logic [7:0] OFS_MP_STATUS = 8'h08;

endpackage

`default_nettype wire

// File: logic/noc_buffer.sv
`default_nettype none

module noc_buffer #(
   parameter int DEPTH = 4
) (
   input  wire                clk_i,
   input  wire                rst_n_i,
   input  wire na_pkg::flit_t in_flit_i,
   input  wire                in_valid_i,
   output logic               in_ready_o,
   output na_pkg::flit_t      out_flit_o,
   output logic               out_valid_o,
   input  wire                out_ready_i
);

   localparam int AW = $clog2(DEPTH);

   na_pkg::flit_t mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;  // Occupancy, 0 to DEPTH
   logic          push;
   logic          pop;

   assign in_ready_o  = (count != (AW+1)'(DEPTH));
   assign out_valid_o = (count != '0);
   assign out_flit_o  = mem[rd_ptr];   // Show-ahead head flit

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr] <= in_flit_i;
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         count <= count + (AW+1)'(push) - (AW+1)'(pop); // Both may happen together
      end
   end

endmodule

`default_nettype wire

// File: logic/mp_channel.sv
`default_nettype none

module mp_channel (
   input  wire                clk_i,
   input  wire                rst_n_i,
   input  wire                tx_push_i,
   input  wire                tx_last_i,
   input  wire na_pkg::data_t tx_data_i,
   output logic               tx_ready_o,
   output na_pkg::flit_t      out_flit_o,
   output logic               out_valid_o,
   input  wire                out_ready_i
);

   na_pkg::flit_t tx_flit;
   logic          first_q;   // Next pushed word opens a packet

   // Flit assembly from the bus word
   always_comb begin
      tx_flit.last  = tx_last_i;
      tx_flit.first = first_q;
      tx_flit.data  = tx_data_i;
   end

   // A packet starts after reset and after every last flit
   always_ff @(posedge clk_i) begin
      if (!rst_n_i)
         first_q <= 1'b1;
      else if (tx_push_i)
         first_q <= tx_last_i;
   end

   // Flit enters at the ack edge of the send write
   noc_buffer #(
      .DEPTH (na_pkg::TX_DEPTH)
   ) u_tx_buffer (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .in_flit_i   (tx_flit),
      .in_valid_i  (tx_push_i),
      .in_ready_o  (tx_ready_o),  // Low stalls the bus write
      .out_flit_o  (out_flit_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

`default_nettype wire

// File: logic/link_arbiter.sv
`default_nettype none

module link_arbiter (
   input  wire                                          clk_i,
   input  wire                                          rst_n_i,
   input  wire na_pkg::flit_t [na_pkg::VCHANNELS-1:0]   fifo_flit_i,
   input  wire [na_pkg::VCHANNELS-1:0]                  fifo_valid_i,
   output logic [na_pkg::VCHANNELS-1:0]                 fifo_ready_o,
   output na_pkg::flit_t                                link_flit_o,
   output logic [na_pkg::VCHANNELS-1:0]                 link_valid_o,
   input  wire [na_pkg::VCHANNELS-1:0]                  link_ready_i
);

   na_pkg::vc_t grant_q;
   logic        locked_q;  // Packet in flight or flit on offer
   na_pkg::vc_t sel;
   logic        accept;

   // Round robin starting after the channel last served
   always_comb begin
      na_pkg::vc_t idx;
      idx = '0;
      sel = grant_q;
      if (!locked_q) begin
         for (int i = na_pkg::VCHANNELS; i >= 1; i--) begin
            idx = na_pkg::vc_t'((int'(grant_q) + i) % na_pkg::VCHANNELS);
            if (fifo_valid_i[idx])
               sel = idx; // Nearest successor wins
         end
      end
   end

   always_comb begin
      link_valid_o      = '0;
      fifo_ready_o      = '0;
      link_valid_o[sel] = fifo_valid_i[sel];
      fifo_ready_o[sel] = link_ready_i[sel];
   end

   assign link_flit_o = fifo_flit_i[sel];
   assign accept      = fifo_valid_i[sel] & link_ready_i[sel];

   // Offered flit keeps the grant so valid holds under back-pressure
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         grant_q  <= '0;
         locked_q <= 1'b0;
      end else if (fifo_valid_i[sel]) begin
         grant_q  <= sel;
         locked_q <= ~(accept & fifo_flit_i[sel].last); // Free once last is taken
      end
   end

endmodule

`default_nettype wire

// File: logic/na_ctrl.sv
`default_nettype none

module na_ctrl #(
   parameter int TILE_ID = 0
) (
   input  wire                                        clk_i,
   input  wire                                        rst_n_i,
   input  wire                                        wb_cyc_i,
   input  wire                                        wb_stb_i,
   input  wire                                        wb_we_i,
   input  wire [na_pkg::ADDR_W-1:0]                   wb_adr_i,
   input  wire na_pkg::data_t                         wb_dat_i,
   output na_pkg::data_t                              wb_dat_o,
   output logic                                       wb_ack_o,
   output logic                                       wb_err_o,
   input  wire na_pkg::flit_t [na_pkg::VCHANNELS-1:0] rx_flit_i,
   input  wire [na_pkg::VCHANNELS-1:0]                rx_valid_i,
   input  wire [na_pkg::VCHANNELS-1:0]                tx_ready_i,
   output logic [na_pkg::VCHANNELS-1:0]               tx_push_o,
   output logic                                       tx_last_o,
   output na_pkg::data_t                              tx_data_o,
   output logic [na_pkg::VCHANNELS-1:0]               rx_pop_o,
   output logic                                       irq_o
);

   logic [1:0]  region;
   logic [7:0]  ofs;
   na_pkg::vc_t vc;
   logic        conf_sel;
   logic        mp_sel;
   logic        send;     // Write to DATA or LAST
   logic        rx_read;  // Pop of a received flit
   logic        mapped;
   logic        req;
   logic        bad;
   logic        stall;
   logic        irq_en_q;

   assign region = wb_adr_i[21:20];
   assign ofs    = wb_adr_i[7:0];
   assign vc     = na_pkg::vc_t'(wb_adr_i[8]);

   assign conf_sel = (wb_adr_i[na_pkg::ADDR_W-1:22] == '0) && (region == na_pkg::REGION_CONF)
                     && (wb_adr_i[19:8] == '0);
   assign mp_sel   = (wb_adr_i[na_pkg::ADDR_W-1:22] == '0) && (region == na_pkg::REGION_MP)
                     && (wb_adr_i[19:9] == '0);

   assign send    = mp_sel & wb_we_i & (ofs == na_pkg::OFS_MP_DATA || ofs == na_pkg::OFS_MP_LAST);
   assign rx_read = mp_sel & ~wb_we_i & (ofs == na_pkg::OFS_MP_DATA);

   always_comb begin
      mapped = 1'b0;
      if (conf_sel)
         mapped = (ofs == na_pkg::OFS_TILEID) || (ofs == na_pkg::OFS_NVC)
                  || (ofs == na_pkg::OFS_IRQ_EN);
      else if (mp_sel)
         mapped = send | rx_read | (~wb_we_i & (ofs == na_pkg::OFS_MP_STATUS));
   end

   // New request only while no answer is out
   assign req   = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
   assign bad   = ~mapped | (rx_read & ~rx_valid_i[vc]);
   assign stall = send & ~tx_ready_i[vc];   // Wait for room in the TX buffer

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wb_ack_o <= 1'b0;
         wb_err_o <= 1'b0;
         irq_en_q <= 1'b0;
      end else begin
         wb_ack_o <= req & ~bad & ~stall;
         wb_err_o <= req & bad;
         if (wb_ack_o && wb_we_i && conf_sel && ofs == na_pkg::OFS_IRQ_EN)
            irq_en_q <= wb_dat_i[0];
      end
   end

   // Read data, valid in the ack cycle
   always_comb begin
      wb_dat_o = '0;
      if (conf_sel) begin
         case (ofs)
            na_pkg::OFS_TILEID: wb_dat_o = na_pkg::data_t'(TILE_ID);
            na_pkg::OFS_NVC:    wb_dat_o = na_pkg::data_t'(na_pkg::VCHANNELS);
            na_pkg::OFS_IRQ_EN: wb_dat_o[0] = irq_en_q;
            default:            wb_dat_o = '0;
         endcase
      end else if (mp_sel) begin
         if (ofs == na_pkg::OFS_MP_STATUS)
            wb_dat_o[1:0] = {rx_flit_i[vc].last, rx_valid_i[vc]};
         else
            wb_dat_o = rx_flit_i[vc].data;
      end
   end

   // Strobes fire in the ack cycle, committing at its closing edge
   always_comb begin
      tx_push_o     = '0;
      rx_pop_o      = '0;
      tx_push_o[vc] = wb_ack_o & send;
      rx_pop_o[vc]  = wb_ack_o & rx_read;
   end

   assign tx_last_o = (ofs == na_pkg::OFS_MP_LAST);
   assign tx_data_o = wb_dat_i;

   assign irq_o = irq_en_q & (|rx_valid_i);

endmodule

`default_nettype wire

// File: logic/na_top.sv
`default_nettype none

module na_top #(
   parameter int TILE_ID = 0
) (
   input  wire                            clk_i,
   input  wire                            rst_n_i,
   input  wire                            wb_cyc_i,
   input  wire                            wb_stb_i,
   input  wire                            wb_we_i,
   input  wire [na_pkg::ADDR_W-1:0]       wb_adr_i,
   input  wire na_pkg::data_t             wb_dat_i,
   output na_pkg::data_t                  wb_dat_o,
   output logic                           wb_ack_o,
   output logic                           wb_err_o,
   input  wire na_pkg::flit_t             noc_in_flit_i,
   input  wire [na_pkg::VCHANNELS-1:0]    noc_in_valid_i,
   output logic [na_pkg::VCHANNELS-1:0]   noc_in_ready_o,
   output na_pkg::flit_t                  noc_out_flit_o,
   output logic [na_pkg::VCHANNELS-1:0]   noc_out_valid_o,
   input  wire [na_pkg::VCHANNELS-1:0]    noc_out_ready_i,
   output logic                           irq_o
);

   // Receive side, buffer to bus
   na_pkg::flit_t [na_pkg::VCHANNELS-1:0] rx_flit;
   logic [na_pkg::VCHANNELS-1:0]          rx_valid;
   logic [na_pkg::VCHANNELS-1:0]          rx_pop;

   // Transmit side, bus to channel to arbiter
   logic [na_pkg::VCHANNELS-1:0]          tx_push;
   logic [na_pkg::VCHANNELS-1:0]          tx_ready;
   logic                                  tx_last;
   na_pkg::data_t                         tx_data;
   na_pkg::flit_t [na_pkg::VCHANNELS-1:0] out_flit;
   logic [na_pkg::VCHANNELS-1:0]          out_valid;
   logic [na_pkg::VCHANNELS-1:0]          out_ready;

   na_ctrl #(
      .TILE_ID (TILE_ID)
   ) u_ctrl (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wb_cyc_i   (wb_cyc_i),
      .wb_stb_i   (wb_stb_i),
      .wb_we_i    (wb_we_i),
      .wb_adr_i   (wb_adr_i),
      .wb_dat_i   (wb_dat_i),
      .wb_dat_o   (wb_dat_o),
      .wb_ack_o   (wb_ack_o),
      .wb_err_o   (wb_err_o),
      .rx_flit_i  (rx_flit),
      .rx_valid_i (rx_valid),
      .tx_ready_i (tx_ready),
      .tx_push_o  (tx_push),
      .tx_last_o  (tx_last),
      .tx_data_o  (tx_data),
      .rx_pop_o   (rx_pop),
      .irq_o      (irq_o)
   );

   for (genvar v = 0; v < na_pkg::VCHANNELS; v++) begin : g_vc
      // Link flit shared, valid and ready per channel
      noc_buffer #(
         .DEPTH (na_pkg::RX_DEPTH)
      ) u_rx_buffer (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .in_flit_i   (noc_in_flit_i),
         .in_valid_i  (noc_in_valid_i[v]),
         .in_ready_o  (noc_in_ready_o[v]),
         .out_flit_o  (rx_flit[v]),
         .out_valid_o (rx_valid[v]),
         .out_ready_i (rx_pop[v])
      );

      mp_channel u_mp_channel (
         .clk_i       (clk_i),
         .rst_n_i     (rst_n_i),
         .tx_push_i   (tx_push[v]),
         .tx_last_i   (tx_last),
         .tx_data_i   (tx_data),
         .tx_ready_o  (tx_ready[v]),
         .out_flit_o  (out_flit[v]),
         .out_valid_o (out_valid[v]),
         .out_ready_i (out_ready[v])
      );
   end

   link_arbiter u_arbiter (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .fifo_flit_i  (out_flit),
      .fifo_valid_i (out_valid),
      .fifo_ready_o (out_ready),
      .link_flit_o  (noc_out_flit_o),
      .link_valid_o (noc_out_valid_o),
      .link_ready_i (noc_out_ready_i)
   );

endmodule

`default_nettype wire

// File: dv/tb_top.sv
`default_nettype none

module tb_top;

   localparam int BUS_TIMEOUT = 200;

   logic                         clk_i;
   logic                         rst_n_i;
   logic                         wb_cyc_i;
   logic                         wb_stb_i;
   logic                         wb_we_i;
   logic [na_pkg::ADDR_W-1:0]    wb_adr_i;
   na_pkg::data_t                wb_dat_i;
   na_pkg::data_t                wb_dat_o;
   logic                         wb_ack_o;
   logic                         wb_err_o;
   na_pkg::flit_t                noc_in_flit_i;
   logic [na_pkg::VCHANNELS-1:0] noc_in_valid_i;
   logic [na_pkg::VCHANNELS-1:0] noc_in_ready_o;
   na_pkg::flit_t                noc_out_flit_o;
   logic [na_pkg::VCHANNELS-1:0] noc_out_valid_o;
   logic [na_pkg::VCHANNELS-1:0] noc_out_ready_i;
   logic                         irq_o;

   int            seed = 32560;
   logic          irq_en_m;                           // Last enable written
   bit            inj_done;                           // Link injection finished
   na_pkg::flit_t tx_q [na_pkg::VCHANNELS][$];       // Written on the bus and due on the link
   na_pkg::flit_t rx_q [na_pkg::VCHANNELS][$];       // Taken from the link and due on the bus

   na_top #(.TILE_ID(32'h2A)) na_top_inst (.*);

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   function automatic int rand_below(input int n);
      return ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   function automatic logic [na_pkg::ADDR_W-1:0] conf_addr(input logic [7:0] ofs);
      return {2'b00, na_pkg::REGION_CONF, 12'd0, ofs};
   endfunction

   function automatic logic [na_pkg::ADDR_W-1:0] mp_addr(input na_pkg::vc_t vc,
                                                          input logic [7:0] ofs);
      return {2'b00, na_pkg::REGION_MP, 11'd0, vc, ofs};
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] act,
                              input logic [63:0] exp);
      if (act !== exp) begin
         $display("Error: %s = 0x%0h, expected 0x%0h", name, act, exp);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   // One classic cycle with the address held through the ack edge
   task automatic bus_access(input logic we, input logic [na_pkg::ADDR_W-1:0] adr,
                             input na_pkg::data_t wdat, output na_pkg::data_t rdat,
                             output logic err);
      int waited;
      @(negedge clk_i);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = wdat;
      waited   = 0;
      do begin
         @(negedge clk_i);
         waited++;
         if (waited > BUS_TIMEOUT)
            fail_run("bus request got neither ack nor err in time");
      end while (!(wb_ack_o || wb_err_o));
      rdat = wb_dat_o;
      err  = wb_err_o;
      @(negedge clk_i);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [na_pkg::ADDR_W-1:0] adr, input na_pkg::data_t dat);
      na_pkg::data_t rdat;
      logic          err;
      bus_access(1'b1, adr, dat, rdat, err);
      check_value("wb_err_o", 64'(err), 64'd0);
   endtask

   task automatic bus_read(input logic [na_pkg::ADDR_W-1:0] adr, output na_pkg::data_t dat);
      logic err;
      bus_access(1'b0, adr, '0, dat, err);
      check_value("wb_err_o", 64'(err), 64'd0);
   endtask

   // Random packets on the shared input link with one flit offered at a time
   task automatic drive_link(input int n_flits, input int force_vc, input int max_cycles);
      na_pkg::flit_t f;
      na_pkg::vc_t   vc;
      int            sent;
      int            cycles;
      int            idx;
      int            len;
      bit            holding;
      bit            pend;
      f       = '0;
      vc      = '0;
      sent    = 0;
      cycles  = 0;
      idx     = 0;
      len     = 0;
      holding = 1'b0;
      pend    = 1'b0;
      while (sent < n_flits && cycles < max_cycles) begin
         @(negedge clk_i);
         cycles++;
         if (pend)
            rx_q[vc].push_back(f);   // Taken at the edge just passed
         pend = 1'b0;
         if (!holding && force_vc < 0 && rand_below(4) == 0) begin
            noc_in_valid_i = '0;     // Idle gap
            continue;
         end
         if (!holding) begin
            if (idx == len) begin
               len = 1 + rand_below(6);
               idx = 0;
               vc  = (force_vc < 0) ? na_pkg::vc_t'(rand_below(2)) : na_pkg::vc_t'(force_vc);
            end
            f.data  = $random(seed);
            f.first = (idx == 0);
            f.last  = (idx == len - 1);
            idx++;
            holding = 1'b1;
         end
         noc_in_flit_i  = f;
         noc_in_valid_i = 2'b01 << vc;
         if (noc_in_ready_o[vc]) begin
            pend    = 1'b1;
            holding = 1'b0;
            sent++;
         end
      end
      @(negedge clk_i);
      noc_in_valid_i = '0;
      if (pend)
         rx_q[vc].push_back(f);
   endtask

   // Poll both channels and pop whatever the status reports
   task automatic read_back(input int max_polls);
      na_pkg::data_t st;
      na_pkg::data_t d;
      na_pkg::vc_t   vc;
      int            polls;
      vc    = '0;
      polls = 0;
      while (!inj_done || rx_q[0].size() != 0 || rx_q[1].size() != 0) begin
         polls++;
         if (polls > max_polls)
            fail_run("received flits were not all read back in time");
         bus_read(mp_addr(vc, na_pkg::OFS_MP_STATUS), st);
         if (st[0] && rx_q[vc].size() == 0)
            fail_run("receive status shows a flit that was never injected");
         else if (st[0]) begin
            check_value("wb_dat_o status last", 64'(st[1]), 64'(rx_q[vc][0].last));
            bus_read(mp_addr(vc, na_pkg::OFS_MP_DATA), d);
            check_value("wb_dat_o", 64'(d), 64'(rx_q[vc][0].data));
            rx_q[vc].delete(0);
         end
         vc = ~vc;
      end
   endtask

   // Link monitor with random back-pressure
   initial begin
      na_pkg::flit_t                exp;
      na_pkg::flit_t                prev_flit;
      logic [na_pkg::VCHANNELS-1:0] v;
      logic [na_pkg::VCHANNELS-1:0] prev_valid;
      na_pkg::vc_t                  ch;
      na_pkg::vc_t                  pkt_vc;
      bit                           in_pkt;
      bit                           stalled;
      noc_out_ready_i = '0;
      prev_flit       = '0;
      prev_valid      = '0;
      pkt_vc          = '0;
      in_pkt          = 1'b0;
      stalled         = 1'b0;
      forever begin
         @(negedge clk_i);
         v = noc_out_valid_o;
         if (stalled) begin
            check_value("noc_out_valid_o", 64'(v), 64'(prev_valid));
            check_value("noc_out_flit_o", 64'(noc_out_flit_o), 64'(prev_flit));
         end
         noc_out_ready_i = 2'($random(seed));
         if (v != '0) begin
            check_value("noc_out_valid_o one-hot", 64'($onehot(v)), 64'd1);
            ch = na_pkg::vc_t'(v[1]);
            if (in_pkt && ch != pkt_vc)
               fail_run("a flit of the other channel broke into a packet on the link");
            else if (noc_out_ready_i[ch] && tx_q[ch].size() == 0)
               fail_run("the link sent a flit that was never written");
            else if (noc_out_ready_i[ch]) begin
               exp = tx_q[ch].pop_front();
               check_value("noc_out_flit_o", 64'(noc_out_flit_o), 64'(exp));
               in_pkt = ~exp.last;
               pkt_vc = ch;
            end
         end
         stalled    = (v != '0) && !(|(v & noc_out_ready_i));
         prev_valid = v;
         prev_flit  = noc_out_flit_o;
      end
   end

   // Interrupt follows enable and pending receive flits
   initial begin
      forever begin
         @(negedge clk_i);
         #1;
         if (rst_n_i)
            check_value("irq_o", 64'(irq_o),
                        64'(irq_en_m & (rx_q[0].size() != 0 || rx_q[1].size() != 0)));
      end
   end

   initial begin
      na_pkg::data_t d;
      na_pkg::flit_t f;
      na_pkg::vc_t   vc;
      logic          err;
      int            len;
      int            waited;
      rst_n_i        = 1'b0;
      wb_cyc_i       = 1'b0;
      wb_stb_i       = 1'b0;
      wb_we_i        = 1'b0;
      wb_adr_i       = '0;
      wb_dat_i       = '0;
      noc_in_flit_i  = '0;
      noc_in_valid_i = '0;
      irq_en_m       = 1'b0;
      inj_done       = 1'b0;
      repeat (10) @(posedge clk_i);
      @(negedge clk_i);
      check_value("wb_ack_o wb_err_o irq_o", 64'({wb_ack_o, wb_err_o, irq_o}), 64'd0);
      check_value("noc_out_valid_o", 64'(noc_out_valid_o), 64'd0);
      check_value("noc_in_ready_o", 64'(noc_in_ready_o), 64'b11);
      rst_n_i = 1'b1;

      bus_read(conf_addr(na_pkg::OFS_TILEID), d);
      check_value("wb_dat_o tile id", 64'(d), 64'h2A);
      bus_read(conf_addr(na_pkg::OFS_NVC), d);
      check_value("wb_dat_o channel count", 64'(d), 64'd2);
      bus_read(conf_addr(na_pkg::OFS_IRQ_EN), d);
      check_value("wb_dat_o irq enable", 64'(d[0]), 64'd0);
      bus_write(conf_addr(na_pkg::OFS_IRQ_EN), 32'h1);
      irq_en_m = 1'b1;
      bus_read(conf_addr(na_pkg::OFS_IRQ_EN), d);
      check_value("wb_dat_o irq enable", 64'(d[0]), 64'd1);
      bus_access(1'b0, conf_addr(8'h0C), '0, d, err);   // Unmapped
      check_value("wb_err_o", 64'(err), 64'd1);

      // Send whole packets one after another
      for (int p = 0; p < 14; p++) begin
         vc  = na_pkg::vc_t'(rand_below(2));
         len = 1 + rand_below(6);
         for (int i = 0; i < len; i++) begin
            f.data  = $random(seed);
            f.first = (i == 0);
            f.last  = (i == len - 1);
            tx_q[vc].push_back(f);
            bus_write(mp_addr(vc, f.last ? na_pkg::OFS_MP_LAST : na_pkg::OFS_MP_DATA), f.data);
         end
      end
      waited = 0;
      while (tx_q[0].size() != 0 || tx_q[1].size() != 0) begin
         @(negedge clk_i);
         waited++;
         if (waited > 500)
            fail_run("written flits did not all leave on the link");
      end

      bus_access(1'b0, mp_addr(1'b1, na_pkg::OFS_MP_DATA), '0, d, err);   // Empty pop
      check_value("wb_err_o", 64'(err), 64'd1);
      fork
         begin
            drive_link(60, -1, 3000);
            inj_done = 1'b1;
         end
         read_back(2000);
      join

      // Fill channel 0 past its depth with no reads
      drive_link(na_pkg::RX_DEPTH + 4, 0, 40);
      check_value("noc_in_ready_o", 64'(noc_in_ready_o), 64'b10);
      check_value("buffered flit count", 64'(rx_q[0].size()), 64'(na_pkg::RX_DEPTH));
      bus_write(conf_addr(na_pkg::OFS_IRQ_EN), 32'h0);   // Pending flits now masked
      irq_en_m = 1'b0;
      read_back(200);

      repeat (4) @(negedge clk_i);
      if (noc_in_ready_o != 2'b11 || noc_out_valid_o != '0)
         fail_run("the adapter did not return to idle at the end");
      else begin
         $display("** PASS **");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: list.f
logic/na_pkg.sv
logic/noc_buffer.sv
logic/mp_channel.sv
logic/link_arbiter.sv
logic/na_ctrl.sv
logic/na_top.sv
dv/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the network adapter testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_top -f list.f -o Vtb_top
./obj_dir/Vtb_top 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log || ! grep -q '\*\* PASS \*\*' sim.log; then
   echo "Simulation failed"
   exit 1
fi
echo "Simulation passed"
